// ==== sim/aes_checker.sv ====
`timescale 1ns/1ps

module aes_checker (
  input logic            CLK,
  input logic            RST,
  input logic            in_valid,
  input logic            in_credit,
  input logic            out_credit,
  input logic            out_valid,
  input aes_pkg::block_t out_data
);

  string           name_a [64];                    // expected blocks in send order
  aes_pkg::block_t ct_a [64];
  bit              exact_a [64];                   // latency must be exactly 11
  int              send_a [64];                    // cycle of the in_valid
  int head = 0;
  int tail = 0;
  int sent_idx = 0;                                // next entry to stamp on in_valid
  int cyc = 0;
  int issued = 0;                                  // input credits since reset
  int accepted = 0;                                // blocks taken since reset
  int last_in_cyc = 0;
  int ocred = 0;                                   // model of the core's output credits
  int out_count = 0;                               // all out_valid pulses, kept over reset
  int pass_count = 0;
  int fail_count = 0;
  int err_count = 0;

  // called by the stimulus just before it raises in_valid
  task automatic expect_block(input string name, input aes_pkg::block_t ct, input bit exact);
    name_a[tail]  = name;
    ct_a[tail]    = ct;
    exact_a[tail] = exact;
    tail++;
  endtask

  // sampled mid-cycle, inputs and outputs are settled here
  always @(negedge CLK)
  begin
    int lat;
    cyc++;
    if (!RST)
    begin
      if (out_valid)
      begin
        $display("error: out_valid high while reset is asserted");
        err_count++;
      end
      issued   = 0;
      accepted = 0;
      ocred    = 0;
      head     = tail;                             // block in flight is dropped by reset
      sent_idx = tail;
    end
    else
    begin
      if (in_valid)
      begin
        accepted++;
        last_in_cyc = cyc;
        if (accepted > issued)
        begin
          $display("error: block sent without an input credit");
          err_count++;
        end
        if (sent_idx < 64)
          send_a[sent_idx] = cyc;
        sent_idx++;
      end
      if (in_credit)
      begin
        if (issued > accepted - (in_valid ? 1 : 0))
        begin
          $display("error: second input credit without a block in between");
          err_count++;
        end
        else if (accepted > 0 && cyc - last_in_cyc < aes_pkg::NUM_ROUNDS + 1)
        begin
          $display("error: input credit returned before the block left the rounds");
          err_count++;
        end
        issued++;
      end
      if (out_valid)
      begin
        out_count++;
        if (ocred == 0)
        begin
          $display("error: out_valid without an output credit");
          err_count++;
        end
        else
          ocred--;
        if (head >= tail)
        begin
          $display("error: out_valid with no block expected");
          err_count++;
        end
        else
        begin
          lat = cyc - send_a[head];
          if (lat < 11 || (exact_a[head] && lat != 11))
          begin
            $display("error: %s came out after %0d cycles", name_a[head], lat);
            err_count++;
          end
          if (out_data !== ct_a[head])
          begin
            $display("mismatch %s expected %h actual %h", name_a[head], ct_a[head], out_data);
            fail_count++;
          end
          else
          begin
            $display("pass %s latency %0d", name_a[head], lat);
            pass_count++;
          end
          head++;
        end
      end
      if (out_credit)
      begin
        ocred++;
        if (ocred > aes_pkg::OUT_CREDIT_MAX)
        begin
          $display("error: sink granted more than the allowed output credits");
          err_count++;
        end
      end
    end
  end

endmodule

// ==== sim/aes_tb.sv ====
`timescale 1ns/1ps

module aes_tb;

  logic            CLK;
  logic            RST;
  logic            in_valid;
  aes_pkg::key_t   in_key;
  aes_pkg::block_t in_data;
  logic            in_credit;
  logic            out_credit;
  logic            out_valid;
  aes_pkg::block_t out_data;

  string           t_name [32];                   // trace contents
  aes_pkg::key_t   t_key [32];
  aes_pkg::block_t t_pt [32];
  aes_pkg::block_t t_ct [32];
  int              t_delay [32];
  int num_tests = 0;
  int max_delay = 0;
  int wd_cycles = 0;
  int in_cred_cnt = 0;                             // credits held by the sender
  int sent_cnt = 0;                                // trace blocks sent
  int granted = 0;                                 // output credits granted
  integer seed = 32'h7293;

  aes_top DUT (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (in_valid),
    .in_key     (in_key),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

  aes_checker chk (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;                         // 8 ns period
  end

  // credits come back as single-cycle pulses
  always @(negedge CLK)
  begin
    if (RST && in_credit)
      in_cred_cnt++;
  end

  task automatic read_trace();
    int    fd;
    int    n;
    string line;
    string nm;
    aes_pkg::key_t   k;
    aes_pkg::block_t p;
    aes_pkg::block_t c;
    int    d;
    fd = $fopen("sim/aes_trace.txt", "r");
    if (fd == 0)
      $display("could not open the trace file");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 2 && line[0] != "#")
        begin
          n = $sscanf(line, "%s %h %h %h %d", nm, k, p, c, d);
          if (n == 5 && num_tests < 32)
          begin
            t_name[num_tests]  = nm;
            t_key[num_tests]   = k;
            t_pt[num_tests]    = p;
            t_ct[num_tests]    = c;
            t_delay[num_tests] = d;
            if (d > max_delay)
              max_delay = d;
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // waits for a credit, then one in_valid cycle
  task automatic send_block(input aes_pkg::key_t key, input aes_pkg::block_t pt);
    while (in_cred_cnt == 0)
    begin
      @(posedge CLK);
      #1;
    end
    in_key   = key;
    in_data  = pt;
    in_valid = 1'b1;
    in_cred_cnt--;
    @(posedge CLK);
    #1;
    in_valid = 1'b0;
  endtask

  // a throwaway block holding an output credit is cut short by reset
  task automatic reset_mid_block();
    while (chk.head != chk.tail || granted != chk.out_count)
    begin
      @(posedge CLK);
      #1;
    end
    send_block(~t_key[0], t_pt[0]);
    out_credit = 1'b1;                             // without reset it would come out
    @(posedge CLK);
    #1;
    out_credit = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;                                    // during the tenth step
    in_cred_cnt = 0;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b1;
  endtask

  // sink, one credit per block after the trace delay
  initial
  begin
    out_credit = 1'b0;
    wait (num_tests > 0);
    for (int j = 0; j < num_tests; j++)
    begin
      wait (sent_cnt > j);
      repeat (t_delay[j]) @(posedge CLK);
      #1;
      while (granted - chk.out_count >= aes_pkg::OUT_CREDIT_MAX)
      begin
        @(posedge CLK);
        #1;
      end
      out_credit = 1'b1;
      granted++;
      @(posedge CLK);
      #1;
      out_credit = 1'b0;
    end
  end

  initial
  begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge CLK);
    $display("timeout after %0d cycles, %0d of %0d blocks seen", wd_cycles,
             chk.head, num_tests);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    int  gap;
    bit  exact;
    RST      = 1'b0;
    in_valid = 1'b0;
    in_key   = '0;
    in_data  = '0;
    read_trace();
    if (num_tests == 0)
    begin
      $display("no test vectors read from the trace file");
      $display("Simulation failed");
    end
    else
    begin
      wd_cycles = num_tests * (11 + max_delay) + 50 + 20;  // 20 for the reset test
      repeat (2) @(posedge CLK);
      #1;
      RST = 1'b1;
      for (int i = 0; i < num_tests; i++)
      begin
        if (i == num_tests - 1)
          reset_mid_block();
        gap = $unsigned($random(seed)) % 3;      // idle jitter between sends
        repeat (gap) @(posedge CLK);
        #1;
        while (in_cred_cnt == 0)
        begin
          @(posedge CLK);
          #1;
        end
        exact = (t_delay[i] == 0) && (chk.head == chk.tail);
        chk.expect_block(t_name[i], t_ct[i], exact);
        send_block(t_key[i], t_pt[i]);
        sent_cnt++;
      end
      while (chk.head < num_tests)
      begin
        @(posedge CLK);
        #1;
      end
      repeat (4) @(posedge CLK);
      $display("passed %0d failed %0d errors %0d", chk.pass_count, chk.fail_count,
               chk.err_count);
      if (chk.fail_count == 0 && chk.err_count == 0 && chk.pass_count == num_tests)
        $display("Simulation completed successfully");
      else
        $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim/aes_trace.txt ====
# name key plaintext expected_ciphertext out_credit_delay
# hex fields are 128 bits, delay in cycles, last line runs after a mid-block reset
fips_b      2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32 0
fips_c1     000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a 0
zero_key    00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 20
ones_key    ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 a1f6258c877d5fcd8964484538bfc92c 0
ecb_1       2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97 30
ecb_2       2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf 5
ecb_3       2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688 0
ecb_4       2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4 12
vartxt_msb  00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34 0
vartxt_ones 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff 3f5b8cc9ea855a0afa7347d23e8d664e 0

// ==== source/aes_ctrl.sv ====
`timescale 1ns/1ps

module aes_ctrl (
  input  logic             CLK,
  input  logic             RST,                    // async, active low
  input  logic             in_valid,               // sender spends a credit
  output logic             in_credit,              // credit back to the sender
  input  logic             out_credit,             // credit from the sink
  output logic             out_valid,
  output aes_pkg::block_t  out_data,
  input  aes_pkg::block_t  result,                 // finished state from the datapath
  output logic             load,
  output logic             step,
  output logic             last,
  output aes_pkg::round_t  round_idx
);

  aes_pkg::ctrl_state_t         state_q;
  logic                         arm_q;             // set one cycle after reset
  logic                         init_done_q;       // initial credit already issued
  logic                         buf_full_q;
  aes_pkg::block_t              buf_q;             // one-entry output buffer
  logic [aes_pkg::CREDIT_W-1:0] credit_q;          // output credits held
  logic                         have_credit;
  logic                         move;              // result leaves the datapath
  logic                         buf_load;          // result parks in the buffer

  assign have_credit = (credit_q != '0);
  assign load        = in_valid && (state_q == aes_pkg::IDLE);
  assign step        = (state_q == aes_pkg::RUN);
  assign last        = step && (round_idx == aes_pkg::round_t'(aes_pkg::NUM_ROUNDS));

  // buffer counts as free when it drains this cycle
  assign move      = (state_q == aes_pkg::HOLD) && (!buf_full_q || have_credit);
  assign buf_load  = move && (buf_full_q || !have_credit);  // no bypass possible
  assign in_credit = (arm_q && !init_done_q) || move;
  assign out_valid = have_credit && (buf_full_q || move);
  assign out_data  = buf_full_q ? buf_q : result;  // empty buffer passes the result through

  // round sequencing
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      state_q   <= aes_pkg::IDLE;
      round_idx <= '0;
    end
    else
    begin
      case (state_q)
        aes_pkg::IDLE:
          if (in_valid)
          begin
            state_q   <= aes_pkg::RUN;
            round_idx <= aes_pkg::round_t'(1);     // first step is round 1
          end
        aes_pkg::RUN:
          if (last)
          begin
            state_q   <= aes_pkg::HOLD;
            round_idx <= '0;
          end
          else
            round_idx <= round_idx + 1'b1;
        aes_pkg::HOLD:
          if (move)
            state_q <= aes_pkg::IDLE;              // sender may send next cycle
        default:
          state_q <= aes_pkg::IDLE;
      endcase
    end
  end

  // one-shot input credit after reset
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      arm_q       <= 1'b0;
      init_done_q <= 1'b0;
    end
    else
    begin
      arm_q       <= 1'b1;
      init_done_q <= arm_q;
    end
  end

  // output credits, saturating
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      credit_q <= '0;
    else if (out_credit && !out_valid)
    begin
      if (credit_q != aes_pkg::CREDIT_W'(aes_pkg::OUT_CREDIT_MAX))
        credit_q <= credit_q + 1'b1;
    end
    else if (!out_credit && out_valid)
      credit_q <= credit_q - 1'b1;
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      buf_full_q <= 1'b0;
    else if (buf_load)
      buf_full_q <= 1'b1;                          // refill while draining keeps it full
    else if (out_valid)
      buf_full_q <= 1'b0;
  end

  always_ff @(posedge CLK)
  begin
    if (buf_load)
      buf_q <= result;
  end

  // sender honours its credit, so a block never lands mid-computation
  a_in_valid_idle: assert property (
    @(posedge CLK) disable iff (!RST) in_valid |-> (state_q == aes_pkg::IDLE)
  );

  // a grant that finds the counter full would be lost
  a_credit_max: assert property (
    @(posedge CLK) disable iff (!RST)
      (out_credit && !out_valid) |-> (credit_q < aes_pkg::OUT_CREDIT_MAX)
  );

endmodule

// ==== source/aes_key_schedule.sv ====
`timescale 1ns/1ps

module aes_key_schedule (
  input  logic            CLK,
  input  logic            RST,                     // async, active low
  input  logic            load,                    // take a fresh cipher key
  input  logic            step,                    // advance one round key
  input  aes_pkg::round_t round_idx,               // round being computed, 1..10
  input  aes_pkg::key_t   in_key,                  // cipher key, round key 0
  output aes_pkg::key_t   round_key                // key for the current step
);

  aes_pkg::key_t  key_q;                           // last round key
  aes_pkg::key_t  next_key;                        // key of this step
  aes_pkg::word_t w0;                              // leftmost word
  aes_pkg::word_t w1;
  aes_pkg::word_t w2;
  aes_pkg::word_t w3;                              // rightmost word, feeds g
  aes_pkg::word_t g_rot;                           // w3 rotated one byte left
  aes_pkg::word_t g_sub;                           // after substitution
  aes_pkg::word_t g_word;                          // g-function result
  aes_pkg::byte_t rc;                              // round constant of this step

  genvar i;

  assign w0 = key_q[127:96];
  assign w1 = key_q[95:64];
  assign w2 = key_q[63:32];
  assign w3 = key_q[31:0];

  assign g_rot = {w3[23:0], w3[31:24]};            // rotword

  // subword, one sbox per byte
  generate
    for (i = 0; i < 4; i++)
    begin : g_sbox
      aes_sbox u_sbox (
        .in_byte  (g_rot[8*i +: 8]),
        .out_byte (g_sub[8*i +: 8])
      );
    end
  endgenerate

  assign rc     = aes_pkg::rcon(round_idx);
  assign g_word = {g_sub[31:24] ^ rc, g_sub[23:0]};  // rcon only on the top byte

  // each new word chains off the one to its left
  always_comb
  begin
    next_key[127:96] = w0 ^ g_word;
    next_key[95:64]  = w1 ^ next_key[127:96];
    next_key[63:32]  = w2 ^ next_key[95:64];
    next_key[31:0]   = w3 ^ next_key[63:32];
  end

  assign round_key = next_key;                     // used by the round in the same cycle

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      key_q <= '0;
    else if (load)
      key_q <= in_key;                             // round key 0
    else if (step)
      key_q <= next_key;                           // keep it for the next round
  end

  // the controller never loads and steps at once
  a_load_step_excl: assert property (
    @(posedge CLK) disable iff (!RST) !(load && step)
  );

endmodule

// ==== source/aes_pkg.sv ====
package aes_pkg;

  localparam int BLOCK_W        = 128;             // state / data block width
  localparam int KEY_W          = 128;             // aes-128 only
  localparam int WORD_W         = 32;              // key schedule word
  localparam int BYTE_W         = 8;
  localparam int ROUND_W        = 4;               // holds 0..10
  localparam int NUM_ROUNDS     = 10;
  localparam int OUT_CREDIT_MAX = 2;               // most credits the sink may grant
  localparam int CREDIT_W       = 2;               // wide enough for OUT_CREDIT_MAX

  typedef logic [BLOCK_W-1:0] block_t;             // plaintext, state or ciphertext
  typedef logic [KEY_W-1:0]   key_t;               // cipher key or round key
  typedef logic [WORD_W-1:0]  word_t;              // one column / key word
  typedef logic [BYTE_W-1:0]  byte_t;              // sbox in / out
  typedef logic [ROUND_W-1:0] round_t;             // round index

  // controller states
  typedef enum logic [1:0] {
    IDLE,                                          // waiting for a block
    RUN,                                           // ten round steps
    HOLD                                           // result waits for the output buffer
  } ctrl_state_t;

  // round constant, top byte of the g-function xor
  function automatic byte_t rcon(input round_t idx);
    case (idx)
      4'd1:    rcon = 8'h01;
      4'd2:    rcon = 8'h02;
      4'd3:    rcon = 8'h04;
      4'd4:    rcon = 8'h08;
      4'd5:    rcon = 8'h10;
      4'd6:    rcon = 8'h20;
      4'd7:    rcon = 8'h40;
      4'd8:    rcon = 8'h80;
      4'd9:    rcon = 8'h1b;                      // reduction by the aes polynomial
      4'd10:   rcon = 8'h36;
      default: rcon = 8'h00;                      // round 0 has no constant
    endcase
  endfunction

endpackage

// ==== source/aes_round.sv ====
`timescale 1ns/1ps

module aes_round (
  input  logic             CLK,
  input  logic             RST,                    // async, active low
  input  logic             load,                   // initial addroundkey
  input  logic             step,                   // one cipher round
  input  logic             last,                   // final round, no mixcolumns
  input  aes_pkg::block_t  in_data,                // plaintext
  input  aes_pkg::key_t    in_key,                 // cipher key
  input  aes_pkg::key_t    round_key,              // from the key schedule
  output aes_pkg::block_t  result                  // state register
);

  aes_pkg::block_t state_q;
  aes_pkg::byte_t  sub_b [16];                     // subbytes output, byte 0 leftmost
  aes_pkg::block_t shifted;                        // after shiftrows
  aes_pkg::block_t mixed;                          // after mixcolumns
  aes_pkg::block_t next_state;

  genvar n;
  genvar c;

  // multiply by 2 in gf(2^8)
  function automatic aes_pkg::byte_t xtime(input aes_pkg::byte_t b);
    xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // one column, top byte is row 0
  function automatic aes_pkg::word_t mix_col(input aes_pkg::word_t col);
    aes_pkg::byte_t a0;
    aes_pkg::byte_t a1;
    aes_pkg::byte_t a2;
    aes_pkg::byte_t a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    mix_col[31:24] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;  // 2 3 1 1
    mix_col[23:16] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;  // 1 2 3 1
    mix_col[15:8]  = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;  // 1 1 2 3
    mix_col[7:0]   = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);  // 3 1 1 2
  endfunction

  // subbytes, bytes are column major
  generate
    for (n = 0; n < 16; n++)
    begin : g_sub
      aes_sbox u_sbox (
        .in_byte  (state_q[aes_pkg::BLOCK_W-1-8*n -: 8]),
        .out_byte (sub_b[n])
      );
      // shiftrows, row r = n%4 rotates left by r columns
      assign shifted[aes_pkg::BLOCK_W-1-8*n -: 8] = sub_b[(((n / 4) + (n % 4)) % 4) * 4 + (n % 4)];
    end
  endgenerate

  generate
    for (c = 0; c < 4; c++)
    begin : g_mix
      assign mixed[aes_pkg::BLOCK_W-1-32*c -: 32] =
        mix_col(shifted[aes_pkg::BLOCK_W-1-32*c -: 32]);
    end
  endgenerate

  assign next_state = (last ? shifted : mixed) ^ round_key;  // addroundkey

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      state_q <= '0;
    else if (load)
      state_q <= in_data ^ in_key;                 // round 0
    else if (step)
      state_q <= next_state;
  end

  assign result = state_q;

endmodule

// ==== source/aes_sbox.sv ====
`timescale 1ns/1ps

module aes_sbox (
  input  aes_pkg::byte_t in_byte,                  // byte to substitute
  output aes_pkg::byte_t out_byte                  // forward sbox value
);

  logic [127:0] row;                               // one table row, 16 entries

  // upper nibble picks the row
  always_comb
  begin
    case (in_byte[7:4])
      4'h0: row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
      4'h1: row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
      4'h2: row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
      4'h3: row = 128'h04c723c3_1896059a_071280e2_eb27b275;
      4'h4: row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
      4'h5: row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
      4'h6: row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
      4'h7: row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
      4'h8: row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
      4'h9: row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
      4'ha: row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
      4'hb: row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
      4'hc: row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
      4'hd: row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
      4'he: row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
      default: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;  // row f
    endcase
  end

  // lower nibble picks the column, entry 0 is leftmost
  assign out_byte = row[8 * (15 - in_byte[3:0]) +: 8];

endmodule

// ==== source/aes_top.sv ====
`timescale 1ns/1ps

module aes_top (
  input  logic             CLK,
  input  logic             RST,                    // async, active low
  input  logic             in_valid,
  input  aes_pkg::key_t    in_key,
  input  aes_pkg::block_t  in_data,
  output logic             in_credit,
  input  logic             out_credit,
  output logic             out_valid,
  output aes_pkg::block_t  out_data
);

  logic            load;
  logic            step;
  logic            last;
  aes_pkg::round_t round_idx;
  aes_pkg::block_t result;                         // datapath state
  aes_pkg::key_t   round_key;                      // key of the current step

  aes_ctrl u_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .result     (result),
    .load       (load),
    .step       (step),
    .last       (last),
    .round_idx  (round_idx)
  );

  aes_round u_round (
    .CLK       (CLK),
    .RST       (RST),
    .load      (load),
    .step      (step),
    .last      (last),
    .in_data   (in_data),
    .in_key    (in_key),
    .round_key (round_key),
    .result    (result)
  );

  aes_key_schedule u_key_schedule (
    .CLK       (CLK),
    .RST       (RST),
    .load      (load),
    .step      (step),
    .round_idx (round_idx),
    .in_key    (in_key),
    .round_key (round_key)
  );

endmodule

// ==== src.f ====
source/aes_pkg.sv
source/aes_sbox.sv
source/aes_key_schedule.sv
source/aes_round.sv
source/aes_ctrl.sv
source/aes_top.sv
sim/aes_checker.sv
sim/aes_tb.sv
